// ==== hw/dnc_strength_cfg.svh ====
`ifndef DNC_STRENGTH_CFG_SVH
`define DNC_STRENGTH_CFG_SVH

////////////////////////////////////////////////////////////
// Fixed-point format
////////////////////////////////////////////////////////////

// Width of one Q16.16 word
`define DNC_DATA_WIDTH 32

// Fraction bits of the Q16.16 format
`define DNC_FRAC_BITS 16

////////////////////////////////////////////////////////////
// Interface shape
////////////////////////////////////////////////////////////

// One write strength plus three read strengths
`define DNC_NUM_STRENGTHS 4

// Piecewise-linear segments over [-4.0, +4.0)
`define DNC_NUM_SEGMENTS 8

// Words in flight, also collector buffer depth
`define DNC_CREDITS 2

`endif

// ==== hw/dnc_strength_pkg.sv ====
`include "dnc_strength_cfg.svh"

package dnc_strength_pkg;

  ////////////////////////////////////////////////////////////
  // Data types
  ////////////////////////////////////////////////////////////

  // Signed Q16.16 value
  typedef logic signed [`DNC_DATA_WIDTH-1:0] fixed_t;

  // One interface word, write strength in the top bits
  typedef struct packed {
    fixed_t                               write_strength;
    fixed_t [`DNC_NUM_STRENGTHS-2:0]      read_strength;
  } strength_vec_t;

  // Per-lane issue slot
  typedef struct packed {
    logic   valid;
    fixed_t value;
  } lane_issue_t;

  // Chord coefficients of one segment
  typedef struct packed {
    fixed_t slope;
    fixed_t intercept;
  } seg_coef_t;

  ////////////////////////////////////////////////////////////
  // Softplus chord table
  ////////////////////////////////////////////////////////////

  // Segment k spans [-4+k, -3+k)
  // Chord through softplus at both ends, rounded to Q16.16
  localparam seg_coef_t oneplus_table [`DNC_NUM_SEGMENTS] = '{
    '{slope: 32'sh0000_07CB, intercept: 32'sh0000_23D0},  // [-4,-3)
    '{slope: 32'sh0000_140E, intercept: 32'sh0000_489B},  // [-3,-2)
    '{slope: 32'sh0000_2FB4, intercept: 32'sh0000_7FE5},  // [-2,-1)
    '{slope: 32'sh0000_6140, intercept: 32'sh0000_B172},  // [-1, 0)
    '{slope: 32'sh0000_9EC0, intercept: 32'sh0000_B172},  // [ 0, 1)
    '{slope: 32'sh0000_D04C, intercept: 32'sh0000_7FE5},  // [ 1, 2)
    '{slope: 32'sh0000_EBF2, intercept: 32'sh0000_489B},  // [ 2, 3)
    '{slope: 32'sh0000_F835, intercept: 32'sh0000_23D0}   // [ 3, 4)
  };

endpackage

// ==== hw/dnc_strength_dispatch.sv ====
`timescale 1ns/1ps
`include "dnc_strength_cfg.svh"

module dnc_strength_dispatch
  import dnc_strength_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  logic          in_req,
  input  strength_vec_t in_data,
  output logic          in_ack,
  input  logic          credit_return,
  output lane_issue_t   lane_issue [`DNC_NUM_STRENGTHS]
);

  localparam int CREDIT_W = $clog2(`DNC_CREDITS + 1);

  // Acceptor states
  localparam logic ST_IDLE = 1'b0;
  localparam logic ST_ACK  = 1'b1;

  logic                state;
  logic [CREDIT_W-1:0] credits;
  logic                take;
  logic                issue_valid;
  strength_vec_t       word_q;

  // Accept only with a free slot downstream
  assign take = (state == ST_IDLE) && in_req && (credits != '0);

  ////////////////////////////////////////////////////////////
  // Four-phase acceptor
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= ST_IDLE;
      in_ack      <= 1'b0;
      issue_valid <= 1'b0;
    end else begin
      // Issue pulse lasts a single cycle
      issue_valid <= take;
      if (take) begin
        state  <= ST_ACK;
        in_ack <= 1'b1;
      end else if ((state == ST_ACK) && !in_req) begin
        // Source released req, close the handshake
        state  <= ST_IDLE;
        in_ack <= 1'b0;
      end
    end
  end

  // Word captured on acceptance
  always_ff @(posedge clk) begin
    if (take) begin
      word_q <= in_data;
    end
  end

  // Unretired words, one in per take, one back per return
  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= CREDIT_W'(`DNC_CREDITS);
    end else begin
      credits <= credits + CREDIT_W'(credit_return) - CREDIT_W'(take);
    end
  end

  ////////////////////////////////////////////////////////////
  // Lane split
  ////////////////////////////////////////////////////////////

  // Lane 0 is the write strength, the rest are read strengths
  always_comb begin
    lane_issue[0] = '{valid: issue_valid, value: word_q.write_strength};
    for (int i = 1; i < `DNC_NUM_STRENGTHS; i++) begin
      lane_issue[i] = '{valid: issue_valid, value: word_q.read_strength[i-1]};
    end
  end

endmodule

// ==== hw/dnc_oneplus_lane.sv ====
`timescale 1ns/1ps
`include "dnc_strength_cfg.svh"

module dnc_oneplus_lane
  import dnc_strength_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  lane_issue_t lane_issue,
  output fixed_t      lane_result,
  output logic        lane_valid
);

  localparam int W     = `DNC_DATA_WIDTH;
  localparam int FRAC  = `DNC_FRAC_BITS;
  localparam int SEG_W = $clog2(`DNC_NUM_SEGMENTS);

  // Q16.16 constants
  localparam fixed_t FIX_ONE = fixed_t'(1) <<< FRAC;
  localparam fixed_t FIX_LO  = -(fixed_t'(`DNC_NUM_SEGMENTS / 2) <<< FRAC);
  localparam fixed_t FIX_HI  = fixed_t'(`DNC_NUM_SEGMENTS / 2) <<< FRAC;

  // Stage 1 signals
  fixed_t           x_offset;
  logic [SEG_W-1:0] seg_idx;
  logic             s1_valid;
  fixed_t           s1_x;
  logic             s1_below;
  logic             s1_above;
  seg_coef_t        s1_coef;

  // Stage 2 signals
  logic signed [2*W-1:0] s1_prod;
  logic signed [2*W-1:0] s1_prod_sh;
  logic                  s2_valid;
  fixed_t                s2_x;
  logic                  s2_below;
  logic                  s2_above;
  fixed_t                s2_term;
  fixed_t                s2_intercept;

  ////////////////////////////////////////////////////////////
  // Stage 1, classify and fetch coefficients
  ////////////////////////////////////////////////////////////

  // Shift range up so the integer bits give the segment
  assign x_offset = lane_issue.value - FIX_LO;
  assign seg_idx  = x_offset[FRAC +: SEG_W];

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= lane_issue.valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_x     <= lane_issue.value;
    s1_below <= lane_issue.value < FIX_LO;
    s1_above <= lane_issue.value >= FIX_HI;
    // Index is don't-care when saturated
    s1_coef  <= oneplus_table[seg_idx];
  end

  ////////////////////////////////////////////////////////////
  // Stage 2, slope times x
  ////////////////////////////////////////////////////////////

  // Full Q32.32 product, back to Q16.16
  assign s1_prod    = s1_coef.slope * s1_x;
  assign s1_prod_sh = s1_prod >>> FRAC;

  always_ff @(posedge clk) begin
    if (reset) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    s2_x         <= s1_x;
    s2_below     <= s1_below;
    s2_above     <= s1_above;
    s2_term      <= s1_prod_sh[W-1:0];
    s2_intercept <= s1_coef.intercept;
  end

  ////////////////////////////////////////////////////////////
  // Stage 3, intercept and the +1 of oneplus
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      lane_valid <= 1'b0;
    end else begin
      lane_valid <= s2_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s2_below) begin
      // Softplus treated as zero
      lane_result <= FIX_ONE;
    end else if (s2_above) begin
      // Softplus treated as identity
      lane_result <= s2_x + FIX_ONE;
    end else begin
      lane_result <= s2_term + s2_intercept + FIX_ONE;
    end
  end

endmodule

// ==== hw/dnc_strength_collect.sv ====
`timescale 1ns/1ps
`include "dnc_strength_cfg.svh"

module dnc_strength_collect
  import dnc_strength_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  fixed_t        lane_result [`DNC_NUM_STRENGTHS],
  input  logic          lane_valid [`DNC_NUM_STRENGTHS],
  output logic          out_req,
  input  logic          out_ack,
  output strength_vec_t out_data,
  output logic          credit_return
);

  localparam int DEPTH = `DNC_CREDITS;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  strength_vec_t    buf_mem [DEPTH];
  strength_vec_t    wr_word;
  logic             wr_en;
  logic             retire;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // Lanes run in lockstep, all valids rise together
  always_comb begin
    wr_en = 1'b1;
    for (int i = 0; i < `DNC_NUM_STRENGTHS; i++) begin
      wr_en = wr_en & lane_valid[i];
    end
  end

  // Reassemble the word in lane order
  always_comb begin
    wr_word.write_strength = lane_result[0];
    for (int i = 1; i < `DNC_NUM_STRENGTHS; i++) begin
      wr_word.read_strength[i-1] = lane_result[i];
    end
  end

  // Ack seen while req still high, exactly one cycle
  assign retire        = out_req && out_ack;
  assign credit_return = retire;
  assign out_data      = buf_mem[rd_ptr];

  ////////////////////////////////////////////////////////////
  // Result buffer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wr_en) begin
      buf_mem[wr_ptr] <= wr_word;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (retire) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(wr_en) - CNT_W'(retire);
    end
  end

  ////////////////////////////////////////////////////////////
  // Output four-phase handshake
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      out_req <= 1'b0;
    end else if (retire) begin
      out_req <= 1'b0;
    end else if (!out_req && !out_ack && (count != '0)) begin
      // Previous ack must be gone before the next req
      out_req <= 1'b1;
    end
  end

endmodule

// ==== hw/dnc_strength_top.sv ====
`timescale 1ns/1ps
`include "dnc_strength_cfg.svh"

module dnc_strength_top
  import dnc_strength_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  logic          in_req,
  input  strength_vec_t in_data,
  output logic          in_ack,
  output logic          out_req,
  output strength_vec_t out_data,
  input  logic          out_ack
);

  ////////////////////////////////////////////////////////////
  // Internal connections
  ////////////////////////////////////////////////////////////

  // Dispatcher to lanes
  lane_issue_t lane_issue [`DNC_NUM_STRENGTHS];

  // Lanes to collector
  fixed_t      lane_result [`DNC_NUM_STRENGTHS];
  logic        lane_valid [`DNC_NUM_STRENGTHS];

  // Collector back to dispatcher
  logic        credit_return;

  // Input side, credit gated
  dnc_strength_dispatch u_dispatch (
    .clk           (clk),
    .reset         (reset),
    .in_req        (in_req),
    .in_data       (in_data),
    .in_ack        (in_ack),
    .credit_return (credit_return),
    .lane_issue    (lane_issue)
  );

  // One oneplus pipeline per strength
  for (genvar g = 0; g < `DNC_NUM_STRENGTHS; g++) begin : g_lane
    dnc_oneplus_lane u_lane (
      .clk         (clk),
      .reset       (reset),
      .lane_issue  (lane_issue[g]),
      .lane_result (lane_result[g]),
      .lane_valid  (lane_valid[g])
    );
  end

  // Output side, in-order return
  dnc_strength_collect u_collect (
    .clk           (clk),
    .reset         (reset),
    .lane_result   (lane_result),
    .lane_valid    (lane_valid),
    .out_req       (out_req),
    .out_ack       (out_ack),
    .out_data      (out_data),
    .credit_return (credit_return)
  );

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int HALF_PERIOD_NS = 5,
  parameter int RESET_CYCLES   = 10
) (
  output logic clk,
  output logic reset
);

  // Free-running clock, 10 ns period
  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD_NS) clk = ~clk;
  end

  // Reset held high for the first cycles, released on an edge
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

// ==== verif/tb_dnc_strength.sv ====
`timescale 1ns/1ps
`include "dnc_strength_cfg.svh"

module tb_dnc_strength
  import dnc_strength_pkg::*;
();

  localparam int     TIMEOUT     = 1000;
  localparam int     HOLD_CYCLES = 40;
  localparam int     RAND_WORDS  = 48;
  localparam int     RAND_SPAN   = 6 << `DNC_FRAC_BITS;
  localparam fixed_t FIX_ONE     = 32'sh0001_0000;
  localparam fixed_t FIX_FOUR    = 32'sh0004_0000;

  logic          clk;
  logic          reset;
  logic          in_req;
  strength_vec_t in_data;
  logic          in_ack;
  logic          out_req;
  strength_vec_t out_data;
  logic          out_ack;

  int            seed;
  int            stim_words;
  strength_vec_t word_q [$];
  strength_vec_t exp_q [$];

  // Handshake edge counters for the back-pressure rule
  int            in_rises  = 0;
  int            out_rises = 0;
  logic          in_ack_d  = 1'b0;
  logic          out_ack_d = 1'b0;

  tb_clock_gen clk_gen (
    .clk   (clk),
    .reset (reset)
  );

  dnc_strength_top uut (
    .clk      (clk),
    .reset    (reset),
    .in_req   (in_req),
    .in_data  (in_data),
    .in_ack   (in_ack),
    .out_req  (out_req),
    .out_data (out_data),
    .out_ack  (out_ack)
  );

  ////////////////////////////////////////////////////////////
  // Failure reporting and compare tasks
  ////////////////////////////////////////////////////////////

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_with_failure($sformatf("CHECK FAILED %s expected %b actual %b", name, exp, act));
    end
  endtask

  task automatic check_fixed(input string name, input fixed_t exp, input fixed_t act);
    if (act !== exp) begin
      stop_with_failure($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_vec(input string name, input strength_vec_t exp,
                           input strength_vec_t act);
    if (act !== exp) begin
      stop_with_failure($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Vector helpers and reference model
  ////////////////////////////////////////////////////////////

  function automatic strength_vec_t make_vec(input fixed_t w, input fixed_t r0,
                                             input fixed_t r1, input fixed_t r2);
    strength_vec_t v;
    v.write_strength   = w;
    v.read_strength[0] = r0;
    v.read_strength[1] = r1;
    v.read_strength[2] = r2;
    return v;
  endfunction

  // Lane 0 is the write strength
  function automatic fixed_t field_of(input strength_vec_t v, input int i);
    if (i == 0) begin
      return v.write_strength;
    end else begin
      return v.read_strength[i-1];
    end
  endfunction

  function automatic string field_name(input int i);
    if (i == 0) begin
      return "write";
    end else begin
      return $sformatf("read%0d", i - 1);
    end
  endfunction

  function automatic bit has_saturated_field(input strength_vec_t v);
    bit sat;
    sat = 1'b0;
    for (int i = 0; i < `DNC_NUM_STRENGTHS; i++) begin
      if (field_of(v, i) < -FIX_FOUR || field_of(v, i) >= FIX_FOUR) begin
        sat = 1'b1;
      end
    end
    return sat;
  endfunction

  // 1 + softplus(x) from the chord of each unit interval
  function automatic fixed_t oneplus_ref(input fixed_t x);
    int        seg;
    longint    prod;
    seg_coef_t coef;
    if (x < -FIX_FOUR) begin
      return FIX_ONE;
    end else if (x >= FIX_FOUR) begin
      return x + FIX_ONE;
    end else begin
      // Floor of x picks the segment with -4 mapping to 0
      seg  = int'(x >>> `DNC_FRAC_BITS) + `DNC_NUM_SEGMENTS / 2;
      coef = oneplus_table[seg];
      prod = longint'(coef.slope) * longint'(x);
      return fixed_t'((prod >>> `DNC_FRAC_BITS) + longint'(coef.intercept) +
                      longint'(FIX_ONE));
    end
  endfunction

  function automatic fixed_t random_strength();
    return fixed_t'($random(seed) % RAND_SPAN);
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus setup
  ////////////////////////////////////////////////////////////

  task automatic load_stim();
    int     fd;
    int     got;
    int     line_no;
    string  line;
    fixed_t v [8];
    fd = $fopen("verif/dnc_strength_stim.txt", "r");
    if (fd == 0) begin
      stop_with_failure("could not open verif/dnc_strength_stim.txt");
    end
    line_no = 0;
    while ($fgets(line, fd) != 0) begin
      line_no++;
      // Skip column notes and blank lines
      if (line.len() > 1 && line[0] != "#") begin
        got = $sscanf(line, "%h %h %h %h %h %h %h %h",
                      v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
        if (got != 8) begin
          stop_with_failure($sformatf("stim line %0d holds %0d values instead of 8",
                                      line_no, got));
        end
        word_q.push_back(make_vec(v[0], v[1], v[2], v[3]));
        exp_q.push_back(make_vec(v[4], v[5], v[6], v[7]));
      end
    end
    $fclose(fd);
    stim_words = word_q.size();
    if (stim_words <= `DNC_CREDITS) begin
      stop_with_failure("stim file holds too few words for the back-pressure test");
    end
  endtask

  // Random words go after the file words
  task automatic add_random_words();
    fixed_t w;
    fixed_t r0;
    fixed_t r1;
    fixed_t r2;
    for (int n = 0; n < RAND_WORDS; n++) begin
      w  = random_strength();
      r0 = random_strength();
      r1 = random_strength();
      r2 = random_strength();
      word_q.push_back(make_vec(w, r0, r1, r2));
      exp_q.push_back(make_vec(oneplus_ref(w), oneplus_ref(r0),
                               oneplus_ref(r1), oneplus_ref(r2)));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Bounded handshake waits
  ////////////////////////////////////////////////////////////

  task automatic wait_in_ack(input logic level);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) begin
        stop_with_failure($sformatf("timeout waiting for in_ack to become %b", level));
      end
    end while (in_ack !== level);
  endtask

  task automatic wait_out_req(input logic level);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) begin
        stop_with_failure($sformatf("timeout waiting for out_req to become %b", level));
      end
    end while (out_req !== level);
  endtask

  task automatic check_reset_state();
    int n;
    n = 0;
    // First edge only loads reset values
    @(posedge clk);
    do begin
      @(posedge clk);
      check_bit("reset in_ack", 1'b0, in_ack);
      check_bit("reset out_req", 1'b0, out_req);
      n++;
      if (n > TIMEOUT) begin
        stop_with_failure("timeout waiting for reset to be released");
      end
    end while (reset);
  endtask

  ////////////////////////////////////////////////////////////
  // Source and sink
  ////////////////////////////////////////////////////////////

  task automatic send_word(input strength_vec_t word);
    in_data <= word;
    in_req  <= 1'b1;
    wait_in_ack(1'b1);
    in_req  <= 1'b0;
    wait_in_ack(1'b0);
  endtask

  task automatic recv_word(output strength_vec_t word, input int delay);
    wait_out_req(1'b1);
    // Data is stable while req is high
    word = out_data;
    repeat (delay) @(posedge clk);
    out_ack <= 1'b1;
    wait_out_req(1'b0);
    out_ack <= 1'b0;
  endtask

  task automatic drive_source();
    for (int i = 0; i < word_q.size(); i++) begin
      send_word(word_q[i]);
    end
  endtask

  task automatic compare_word(input int idx, input strength_vec_t got);
    string name;
    if (idx < stim_words) begin
      name = $sformatf("stim word %0d", idx);
    end else begin
      name = $sformatf("random word %0d", idx - stim_words);
    end
    if (has_saturated_field(word_q[idx])) begin
      for (int f = 0; f < `DNC_NUM_STRENGTHS; f++) begin
        check_fixed({name, " ", field_name(f)}, field_of(exp_q[idx], f), field_of(got, f));
      end
    end else begin
      check_vec(name, exp_q[idx], got);
    end
  endtask

  task automatic drain_sink();
    strength_vec_t got;
    int            delay;
    // Sink stays silent so the source stalls on the third word
    repeat (HOLD_CYCLES) @(posedge clk);
    check_bit("back-pressure in_ack", 1'b0, in_ack);
    check_bit("back-pressure out_req", 1'b1, out_req);
    if (in_rises != `DNC_CREDITS) begin
      stop_with_failure($sformatf("%0d words were accepted while the sink held off",
                                  in_rises));
    end
    // Results must come back in the order they went in
    for (int i = 0; i < exp_q.size(); i++) begin
      delay = $unsigned($random(seed)) % 8;
      recv_word(got, delay);
      compare_word(i, got);
    end
  endtask

  // Third in_ack may not rise before the first out_ack
  always @(posedge clk) begin
    in_ack_d  <= in_ack;
    out_ack_d <= out_ack;
    if (in_ack === 1'b1 && in_ack_d === 1'b0) begin
      in_rises <= in_rises + 1;
      if (in_rises == `DNC_CREDITS && out_rises == 0) begin
        stop_with_failure("in_ack rose for a third word before any out_ack");
      end
    end
    if (out_ack === 1'b1 && out_ack_d === 1'b0) begin
      out_rises <= out_rises + 1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    seed    = 46467;
    in_req  = 1'b0;
    in_data = '0;
    out_ack = 1'b0;
    load_stim();
    add_random_words();
    check_reset_state();
    fork
      drive_source();
      drain_sink();
    join
    // No result beyond the words sent
    repeat (HOLD_CYCLES) begin
      @(posedge clk);
      check_bit("idle out_req", 1'b0, out_req);
      check_bit("idle in_ack", 1'b0, in_ack);
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== verif/dnc_strength_stim.txt ====
# columns: write read0 read1 read2 (Q16.16 inputs, hex)
# then expected oneplus for write read0 read1 read2 (Q16.16, hex)
FFFB0000 00050000 FF9C0000 000A0000  00010000 00060000 00010000 000B0000
80000000 00040000 FFFBFFFF 00064000  00010000 00050000 00010000 00074000
00100000 FFFC0000 00030000 FFFB0000  00110000 000104A4 00040C6F 00010000
0003FFFF 00040000 FFFBFFFF FFFC0000  000504A3 00050000 00010000 000104A4
00040000 00040000 00040000 00040000  00050000 00050000 00050000 00050000
FFFBFFFF FFFBFFFF FFFBFFFF FFFBFFFF  00010000 00010000 00010000 00010000
00064000 FFFC0001 80000000 00018000  00074000 000104A4 00010000 0002B857
FF9C0000 00000000 00100000 FFFF8000  00010000 0001B172 00110000 000180D2
FFFC0000 FFFD0000 FFFE0000 FFFF0000  000104A4 00010C71 0001207D 00015032
00000000 00010000 00020000 00030000  0001B172 00025031 0003207F 00040C6F
FFFC8000 FFFD8000 FFFE8000 FFFF8000  00010889 00011678 00013857 000180D2
00008000 00018000 00028000 00038000  000200D2 0002B857 00039678 00048889
00038000 00028000 00018000 00008000  00048889 00039678 0002B857 000200D2
FFFF8000 FFFE8000 FFFD8000 FFFC8000  000180D2 00013857 00011678 00010889
00030000 00020000 00010000 00000000  00040C6F 0003207F 00025031 0001B172
FFFF0000 FFFE0000 FFFD0000 FFFC0000  00015032 0001207D 00010C71 000104A4
FFFC0001 0003FFFF 00004000 FFFF4000  000104A4 000504A3 0001D922 00016882
0001C000 FFFD4000 FFFC0000 00000000  0002EC6A 00011174 000104A4 0001B172
FFFC8000 00000000 00038000 FFFE0000  00010889 0001B172 00048889 0001207D
00010000 FFFF0000 FFFD8000 00028000  00025031 00015032 00011678 00039678
FFFE8000 00020000 00004000 FFFC0000  00013857 0003207F 0001D922 000104A4
00030000 FFFF4000 0001C000 FFFD0000  00040C6F 00016882 0002EC6A 00010C71
FFFD4000 00008000 FFFE0000 0003FFFF  00011174 000200D2 0001207D 000504A3
00018000 FFFC0001 00030000 FFFF8000  0002B857 000104A4 00040C6F 000180D2
00000000 00000000 00000000 00000000  0001B172 0001B172 0001B172 0001B172
FFFF4000 00004000 FFFD8000 00038000  00016882 0001D922 00011678 00048889
00028000 FFFE8000 00010000 FFFC8000  00039678 00013857 00025031 00010889
0003FFFF FFFC0000 0001C000 FFFD4000  000504A3 000104A4 0002EC6A 00011174
FFFE0000 00038000 FFFF0000 00020000  0001207D 00048889 00015032 0003207F
00004000 FFFD0000 00008000 FFFF4000  0001D922 00010C71 000200D2 00016882
000A0000 0001C000 FFFB0000 FFFD4000  000B0000 0002EC6A 00010000 00011174
FFFC0000 00050000 FFFF8000 FFFBFFFF  000104A4 00060000 000180D2 00010000

// ==== tb.f ====
+incdir+hw
hw/dnc_strength_pkg.sv
hw/dnc_strength_dispatch.sv
hw/dnc_oneplus_lane.sv
hw/dnc_strength_collect.sv
hw/dnc_strength_top.sv
verif/tb_clock_gen.sv
verif/tb_dnc_strength.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dnc_strength
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing -Wno-fatal -j $(JOBS)

SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
HEADERS   := hw/dnc_strength_cfg.svh
PASS_TEXT := Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR JOBS VFLAGS"

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
